// ==== hw/msgq_pkg.sv ====
// Mailbox shared definitions

package msgq_pkg;

	// message and queue sizing
	localparam int MSG_W = 32;
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_CNT_W = 4;

	// register byte offsets, decoded from paddr[4:2]
	localparam logic [7:0] ADDR_LED = 8'h00;
	localparam logic [7:0] ADDR_ACTIVE = 8'h04;
	localparam logic [7:0] ADDR_IDLE = 8'h08;
	localparam logic [7:0] ADDR_RESET = 8'h0C;
	localparam logic [7:0] ADDR_PUSH = 8'h10;
	localparam logic [7:0] ADDR_STATUS = 8'h14;

	// tag that turns a message into a doorbell
	localparam logic [7:0] DOORBELL_TAG = 8'hFF;

	// core held in reset this many cycles (plus one) by default
	localparam logic [15:0] IDLE_RESET_VAL = 16'd16;

	// apb request from the core
	typedef struct packed {
		logic [7:0] paddr;
		logic psel;
		logic penable;
		logic pwrite;
		logic [MSG_W-1:0] pwdata;
	} apb_req_t;

	// apb response back to the core
	typedef struct packed {
		logic [MSG_W-1:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// plain data message
	typedef struct packed {
		logic [7:0] tag;
		logic [23:0] payload;
	} msg_data_t;

	// doorbell message, tag is DOORBELL_TAG
	typedef struct packed {
		logic [7:0] tag;
		logic [7:0] src;
		logic [15:0] incr;
	} msg_bell_t;

	// one message word, two views
	typedef union packed {
		msg_data_t data;
		msg_bell_t bell;
	} msg_u;

	// layout of the status register
	typedef struct packed {
		logic [15:0] doorbell_count;
		logic [10:0] rsvd;
		logic full;
		logic [FIFO_CNT_W-1:0] count;
	} status_t;

endpackage

// ==== hw/apb_msg_regs.sv ====
// APB mailbox register block

`timescale 1ns/1ps

module apb_msg_regs import msgq_pkg::*; (
	input  logic                  core_clk,
	input  logic                  rst_n,
	input  apb_req_t              i_apb,
	input  logic                  i_fifo_full,
	input  logic [FIFO_CNT_W-1:0] i_fifo_count,
	input  logic [15:0]           i_doorbell_count,
	output apb_rsp_t              o_apb,
	output logic                  o_push,
	output msg_u                  o_push_msg,
	output logic [3:0]            o_led,
	output logic [15:0]           o_idle_cnt,
	output logic [15:0]           o_active_cnt,
	output logic                  o_rst_req
);

	logic access;
	logic wr_access;
	logic [2:0] reg_idx;
	logic hit_led;
	logic hit_active;
	logic hit_idle;
	logic hit_reset;
	logic hit_push;
	logic hit_status;
	logic mapped;
	logic [MSG_W-1:0] led_q;
	logic [15:0] idle_q;
	logic [15:0] active_q;
	logic [MSG_W-1:0] rdata;
	status_t status;

	// no wait states, every access phase completes
	assign access = i_apb.psel & i_apb.penable;
	assign wr_access = access & i_apb.pwrite;

	// address map decode
	assign reg_idx = i_apb.paddr[4:2];
	assign hit_led = (reg_idx == ADDR_LED[4:2]);
	assign hit_active = (reg_idx == ADDR_ACTIVE[4:2]);
	assign hit_idle = (reg_idx == ADDR_IDLE[4:2]);
	assign hit_reset = (reg_idx == ADDR_RESET[4:2]);
	assign hit_push = (reg_idx == ADDR_PUSH[4:2]);
	assign hit_status = (reg_idx == ADDR_STATUS[4:2]);
	assign mapped = hit_led | hit_active | hit_idle | hit_reset | hit_push | hit_status;

	// push strobe lines up with the edge that ends the access phase
	assign o_push = wr_access & hit_push & ~i_fifo_full;
	assign o_push_msg = i_apb.pwdata;

	// single-cycle request to restart the core reset sequence
	assign o_rst_req = wr_access & hit_reset;

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			led_q <= '0;
			idle_q <= IDLE_RESET_VAL;
			active_q <= '0;
		end else if (wr_access) begin
			if (hit_led) begin
				led_q <= i_apb.pwdata;
			end
			if (hit_idle) begin
				idle_q <= i_apb.pwdata[15:0];
			end
			if (hit_active) begin
				active_q <= i_apb.pwdata[15:0];
			end
		end
	end

	assign o_led = led_q[3:0];
	assign o_idle_cnt = idle_q;
	assign o_active_cnt = active_q;

	// status word
	assign status.doorbell_count = i_doorbell_count;
	assign status.rsvd = '0;
	assign status.full = i_fifo_full;
	assign status.count = i_fifo_count;

	// read mux, push and reset read as zero
	always_comb begin
		rdata = '0;
		if (hit_led) begin
			rdata = led_q;
		end else if (hit_active) begin
			rdata = {16'h0000, active_q};
		end else if (hit_idle) begin
			rdata = {16'h0000, idle_q};
		end else if (hit_status) begin
			rdata = status;
		end
	end

	assign o_apb.prdata = rdata;
	assign o_apb.pready = access;
	// full queue on a push, or a hole in the map
	assign o_apb.pslverr = access & (~mapped | (hit_push & i_apb.pwrite & i_fifo_full));

endmodule

// ==== hw/msg_fifo.sv ====
// Message queue

`timescale 1ns/1ps

module msg_fifo import msgq_pkg::*; (
	input  logic                  core_clk,
	input  logic                  rst_n,
	input  logic                  i_push,
	input  msg_u                  i_push_msg,
	input  logic                  i_pop,
	output msg_u                  o_head,
	output logic                  o_empty,
	output logic                  o_full,
	output logic [FIFO_CNT_W-1:0] o_count
);

	msg_u mem [FIFO_DEPTH];
	logic [FIFO_CNT_W-2:0] wr_ptr;
	logic [FIFO_CNT_W-2:0] rd_ptr;
	logic [FIFO_CNT_W-1:0] count_q;
	logic do_push;
	logic do_pop;

	assign do_push = i_push & ~o_full;
	assign do_pop = i_pop & ~o_empty;

	// storage, no reset needed
	always_ff @(posedge core_clk) begin
		if (do_push) begin
			mem[wr_ptr] <= i_push_msg;
		end
	end

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count_q <= '0;
		end else begin
			if (do_push) begin
				if (wr_ptr == (FIFO_CNT_W-1)'(FIFO_DEPTH - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (do_pop) begin
				if (rd_ptr == (FIFO_CNT_W-1)'(FIFO_DEPTH - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			// simultaneous push and pop leaves the count alone
			case ({do_push, do_pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	assign o_head = mem[rd_ptr];
	assign o_empty = (count_q == '0);
	assign o_full = (count_q == FIFO_CNT_W'(FIFO_DEPTH));
	assign o_count = count_q;

endmodule

// ==== hw/msg_drain.sv ====
// Queue drain and doorbell handling

`timescale 1ns/1ps

module msg_drain import msgq_pkg::*; (
	input  logic        core_clk,
	input  logic        rst_n,
	input  msg_u        i_head,
	input  logic        i_empty,
	input  logic        i_out_ready,
	output logic        o_pop,
	output msg_u        o_out_msg,
	output logic        o_out_valid,
	output logic        o_doorbell_irq,
	output logic [15:0] o_doorbell_count
);

	logic is_bell;
	logic slot_free;
	logic take_bell;
	logic take_data;
	msg_u out_q;
	logic valid_q;
	logic irq_q;
	logic [15:0] bell_cnt_q;

	assign is_bell = (i_head.bell.tag == DOORBELL_TAG);

	// output register empty now, or handed off on this edge
	assign slot_free = ~valid_q | i_out_ready;

	// hold a second doorbell back one cycle so each irq pulse stands alone
	assign o_pop = ~i_empty & slot_free & ~(is_bell & irq_q);
	assign take_bell = o_pop & is_bell;
	assign take_data = o_pop & ~is_bell;

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			irq_q <= 1'b0;
			bell_cnt_q <= '0;
		end else begin
			irq_q <= take_bell;
			if (take_bell) begin
				// wraps at 16 bits
				bell_cnt_q <= bell_cnt_q + i_head.bell.incr;
			end
			if (take_data) begin
				valid_q <= 1'b1;
			end else if (i_out_ready) begin
				valid_q <= 1'b0;
			end
		end
	end

	// outbound word only changes when a new data message is taken
	always_ff @(posedge core_clk) begin
		if (take_data) begin
			out_q <= i_head;
		end
	end

	assign o_out_msg = out_q;
	assign o_out_valid = valid_q;
	assign o_doorbell_irq = irq_q;
	assign o_doorbell_count = bell_cnt_q;

endmodule

// ==== hw/reset_seq.sv ====
// Core reset sequencer

`timescale 1ns/1ps

module reset_seq (
	input  logic        core_clk,
	input  logic        rst_n,
	input  logic [15:0] i_idle_cnt,
	input  logic [15:0] i_active_cnt,
	input  logic        i_rst_req,
	output logic        o_core_rst_n
);

	// two states, 0 holds the core in reset, 1 lets it run
	logic st_active;
	logic [15:0] cnt_q;
	logic active_done;

	// zero active count means run forever
	assign active_done = (i_active_cnt != '0) && (cnt_q == i_active_cnt - 16'd1);

	always_ff @(posedge core_clk) begin
		if (!rst_n) begin
			st_active <= 1'b0;
			cnt_q <= '0;
		end else if (i_rst_req) begin
			// restart from the top, also when already in reset
			st_active <= 1'b0;
			cnt_q <= '0;
		end else if (!st_active) begin
			// counts 0..idle, so idle+1 cycles low
			if (cnt_q == i_idle_cnt) begin
				st_active <= 1'b1;
				cnt_q <= '0;
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
		end else begin
			if (active_done) begin
				st_active <= 1'b0;
				cnt_q <= '0;
			end else if (i_active_cnt != '0) begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	assign o_core_rst_n = st_active;

endmodule

// ==== hw/msgq_sys.sv ====
// Mailbox and system control top

`timescale 1ns/1ps

module msgq_sys import msgq_pkg::*; (
	input  logic       core_clk,
	input  logic       rst_n,
	input  apb_req_t   i_apb,
	output apb_rsp_t   o_apb,
	output msg_u       o_out_msg,
	output logic       o_out_valid,
	input  logic       i_out_ready,
	output logic [3:0] o_led,
	output logic       o_doorbell_irq,
	output logic       o_core_rst_n
);

	logic push;
	msg_u push_msg;
	logic fifo_full;
	logic fifo_empty;
	logic [FIFO_CNT_W-1:0] fifo_count;
	msg_u fifo_head;
	logic pop;
	logic [15:0] doorbell_count;
	logic [15:0] idle_cnt;
	logic [15:0] active_cnt;
	logic rst_req;

	apb_msg_regs u_regs (
		.core_clk         (core_clk),
		.rst_n            (rst_n),
		.i_apb            (i_apb),
		.i_fifo_full      (fifo_full),
		.i_fifo_count     (fifo_count),
		.i_doorbell_count (doorbell_count),
		.o_apb            (o_apb),
		.o_push           (push),
		.o_push_msg       (push_msg),
		.o_led            (o_led),
		.o_idle_cnt       (idle_cnt),
		.o_active_cnt     (active_cnt),
		.o_rst_req        (rst_req)
	);

	msg_fifo u_fifo (
		.core_clk   (core_clk),
		.rst_n      (rst_n),
		.i_push     (push),
		.i_push_msg (push_msg),
		.i_pop      (pop),
		.o_head     (fifo_head),
		.o_empty    (fifo_empty),
		.o_full     (fifo_full),
		.o_count    (fifo_count)
	);

	msg_drain u_drain (
		.core_clk         (core_clk),
		.rst_n            (rst_n),
		.i_head           (fifo_head),
		.i_empty          (fifo_empty),
		.i_out_ready      (i_out_ready),
		.o_pop            (pop),
		.o_out_msg        (o_out_msg),
		.o_out_valid      (o_out_valid),
		.o_doorbell_irq   (o_doorbell_irq),
		.o_doorbell_count (doorbell_count)
	);

	reset_seq u_rst_seq (
		.core_clk     (core_clk),
		.rst_n        (rst_n),
		.i_idle_cnt   (idle_cnt),
		.i_active_cnt (active_cnt),
		.i_rst_req    (rst_req),
		.o_core_rst_n (o_core_rst_n)
	);

endmodule

// ==== testbench/msgq_sys_checker.sv ====
// Mailbox protocol assertions

`timescale 1ns/1ps

module msgq_sys_checker import msgq_pkg::*; (
	input logic     core_clk,
	input logic     rst_n,
	input apb_req_t i_apb,
	input apb_rsp_t o_apb,
	input msg_u     o_out_msg,
	input logic     o_out_valid,
	input logic     i_out_ready,
	input logic     o_doorbell_irq
);

	// stalled outbound word must not move
	out_stable: assert property (@(posedge core_clk) disable iff (!rst_n)
		o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_msg))
	else $error("outbound message changed or dropped while stalled");

	pslverr_access: assert property (@(posedge core_clk) disable iff (!rst_n)
		o_apb.pslverr |-> i_apb.psel && i_apb.penable)
	else $error("pslverr outside the access phase");

	pready_access: assert property (@(posedge core_clk) disable iff (!rst_n)
		o_apb.pready |-> i_apb.psel && i_apb.penable)
	else $error("pready outside the access phase");

	// each doorbell interrupt is a single-cycle pulse
	irq_pulse: assert property (@(posedge core_clk) disable iff (!rst_n)
		o_doorbell_irq |=> !o_doorbell_irq)
	else $error("doorbell interrupt held longer than one cycle");

endmodule

bind msgq_sys msgq_sys_checker u_checker (
	.core_clk       (core_clk),
	.rst_n          (rst_n),
	.i_apb          (i_apb),
	.o_apb          (o_apb),
	.o_out_msg      (o_out_msg),
	.o_out_valid    (o_out_valid),
	.i_out_ready    (i_out_ready),
	.o_doorbell_irq (o_doorbell_irq)
);

// ==== testbench/tb_msgq_sys.sv ====
// Mailbox system testbench

`timescale 1ns/1ps

module tb_msgq_sys import msgq_pkg::*; ();

	localparam int CLK_PERIOD = 40;
	localparam int NUM_STEPS = 50;
	localparam int WATCHDOG_NS = (NUM_STEPS * 40 + 2000) * CLK_PERIOD;
	localparam int WAIT_LIMIT = 1000;

	// table operations
	localparam logic [2:0] OP_WR = 3'd0;
	localparam logic [2:0] OP_RD = 3'd1;
	localparam logic [2:0] OP_PUSH_RND = 3'd2;
	localparam logic [2:0] OP_READY = 3'd3;
	localparam logic [2:0] OP_DRAIN = 3'd4;
	localparam logic [2:0] OP_LED = 3'd5;
	localparam logic [2:0] OP_RSTSEQ = 3'd6;

	// for OP_RSTSEQ exp_rdata is {active cycles, low cycles}
	typedef struct packed {
		logic [2:0] op;
		logic [7:0] offset;
		logic [31:0] data;
		logic [31:0] exp_rdata;
		logic exp_err;
	} step_t;

	step_t steps [NUM_STEPS] = '{
		{OP_WR, ADDR_LED, 32'hA5A5_5A5C, 32'h0, 1'b0},
		{OP_RD, ADDR_LED, 32'h0, 32'hA5A5_5A5C, 1'b0},
		{OP_LED, ADDR_LED, 32'h0, 32'h0000_000C, 1'b0},
		{OP_WR, ADDR_IDLE, 32'h0000_0014, 32'h0, 1'b0},
		{OP_RD, ADDR_IDLE, 32'h0, 32'h0000_0014, 1'b0},
		{OP_WR, ADDR_ACTIVE, 32'h0000_0123, 32'h0, 1'b0},
		{OP_RD, ADDR_ACTIVE, 32'h0, 32'h0000_0123, 1'b0},
		{OP_WR, ADDR_ACTIVE, 32'h0, 32'h0, 1'b0},
		{OP_WR, 8'h18, 32'hDEAD_BEEF, 32'h0, 1'b1},
		{OP_RD, 8'h1C, 32'h0, 32'h0, 1'b1},
		{OP_RD, ADDR_STATUS, 32'h0, 32'h0, 1'b0},
		// in-order delivery under random stalls
		{OP_READY, 8'h00, 32'h2, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_DRAIN, 8'h00, 32'h0, 32'h0, 1'b0},
		// back-pressure, one in the drain plus eight queued
		{OP_READY, 8'h00, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b1},
		{OP_RD, ADDR_STATUS, 32'h0, 32'h0000_0018, 1'b0},
		{OP_READY, 8'h00, 32'h1, 32'h0, 1'b0},
		{OP_DRAIN, 8'h00, 32'h0, 32'h0, 1'b0},
		{OP_RD, ADDR_STATUS, 32'h0, 32'h0, 1'b0},
		// doorbells mixed with data
		{OP_READY, 8'h00, 32'h2, 32'h0, 1'b0},
		{OP_WR, ADDR_PUSH, 32'h1100_2222, 32'h0, 1'b0},
		{OP_WR, ADDR_PUSH, 32'hFF01_1234, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_WR, ADDR_PUSH, 32'hFF02_F000, 32'h0, 1'b0},
		{OP_WR, ADDR_PUSH, 32'hFF03_FFFF, 32'h0, 1'b0},
		{OP_PUSH_RND, ADDR_PUSH, 32'h0, 32'h0, 1'b0},
		{OP_DRAIN, 8'h00, 32'h0, 32'h0, 1'b0},
		{OP_RD, ADDR_STATUS, 32'h0, 32'h0233_0000, 1'b0},
		// core reset sequencing
		{OP_WR, ADDR_IDLE, 32'h0000_0005, 32'h0, 1'b0},
		{OP_RSTSEQ, ADDR_RESET, 32'h0, 32'h0000_0006, 1'b0},
		{OP_WR, ADDR_ACTIVE, 32'h0000_0007, 32'h0, 1'b0},
		{OP_RSTSEQ, ADDR_RESET, 32'h0, 32'h0007_0006, 1'b0},
		{OP_WR, ADDR_ACTIVE, 32'h0, 32'h0, 1'b0}
	};

	logic core_clk;
	logic rst_n;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	msg_u out_msg;
	logic out_valid;
	logic out_ready;
	logic [3:0] led;
	logic doorbell_irq;
	logic core_rst_n;

	logic [31:0] data_lfsr = 32'h5ae4303b;
	logic [31:0] ready_lfsr = 32'h5ae4303b;
	// 0 hold low, 1 hold high, 2 random stalls
	logic [1:0] ready_mode = 2'd0;
	logic [31:0] exp_q [$];
	int bells_exp = 0;
	int irq_seen = 0;
	int checks = 0;
	int errors = 0;

	msgq_sys u_msgq_sys (
		.core_clk       (core_clk),
		.rst_n          (rst_n),
		.i_apb          (apb_req),
		.o_apb          (apb_rsp),
		.o_out_msg      (out_msg),
		.o_out_valid    (out_valid),
		.i_out_ready    (out_ready),
		.o_led          (led),
		.o_doorbell_irq (doorbell_irq),
		.o_core_rst_n   (core_rst_n)
	);

	always #(CLK_PERIOD / 2) core_clk = ~core_clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], data_lfsr[0]};
			data_lfsr = lfsr_step(data_lfsr);
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// setup then access phase, sampled mid access phase
	task automatic apb_access(input logic wr, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		apb_req.paddr = addr;
		apb_req.pwrite = wr;
		apb_req.pwdata = wdata;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		@(posedge core_clk);
		#1;
		apb_req.penable = 1'b1;
		@(negedge core_clk);
		rdata = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		check_value("pready", {31'h0, apb_rsp.pready}, 32'h1);
		@(posedge core_clk);
		#1;
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata,
			output logic err);
		logic [31:0] unused;
		apb_access(1'b1, addr, wdata, unused, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata,
			output logic err);
		apb_access(1'b0, addr, 32'h0, rdata, err);
	endtask

	always begin
		@(posedge core_clk);
		#1;
		case (ready_mode)
			2'd0: out_ready = 1'b0;
			2'd1: out_ready = 1'b1;
			default: begin
				out_ready = ready_lfsr[0];
				ready_lfsr = lfsr_step(ready_lfsr);
			end
		endcase
	end

	// outbound handshake completes on the next rising edge
	always @(negedge core_clk) begin
		logic [31:0] exp_word;
		if (rst_n && out_valid && out_ready) begin
			checks++;
			assert (out_msg.data.tag != 8'hFF) else begin
				errors++;
				$display("[ERROR] %0t ns: doorbell %h seen outbound", $time, out_msg);
			end
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("outbound message %h arrived while none was expected", out_msg);
			end
			if (exp_q.size() != 0) begin
				exp_word = exp_q.pop_front();
				check_value("outbound message", out_msg, exp_word);
			end
		end
		if (rst_n && doorbell_irq) begin
			irq_seen++;
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the test sequence finished");
		$display("Verification failed");
		$finish;
	end

	initial begin
		step_t st;
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic [31:0] rnd;
		logic err;
		int n;
		int m;
		core_clk = 1'b0;
		rst_n = 1'b0;
		apb_req = '0;
		out_ready = 1'b0;
		repeat (2) @(posedge core_clk);
		@(negedge core_clk);
		check_value("outputs in reset",
			{24'h0, led, out_valid, doorbell_irq, apb_rsp.pslverr, core_rst_n}, 32'h0);
		@(posedge core_clk);
		#1;
		rst_n = 1'b1;

		for (int i = 0; i < NUM_STEPS; i++) begin
			st = steps[i];
			case (st.op)
				OP_WR, OP_PUSH_RND: begin
					wdata = st.data;
					if (st.op == OP_PUSH_RND) begin
						// 7-bit tag keeps it clear of the doorbell tag
						take_bits(7, rnd);
						wdata[31:24] = {1'b0, rnd[6:0]};
						take_bits(24, rnd);
						wdata[23:0] = rnd[23:0];
					end
					if (st.offset == ADDR_PUSH && !st.exp_err) begin
						if (wdata[31:24] == 8'hFF) begin
							bells_exp++;
						end else begin
							exp_q.push_back(wdata);
						end
					end
					apb_write(st.offset, wdata, err);
					check_value("pslverr on write", {31'h0, err}, {31'h0, st.exp_err});
				end
				OP_RD: begin
					apb_read(st.offset, rdata, err);
					check_value("pslverr on read", {31'h0, err}, {31'h0, st.exp_err});
					check_value("read data", rdata, st.exp_rdata);
				end
				OP_READY: begin
					@(negedge core_clk);
					ready_mode = st.data[1:0];
					@(posedge core_clk);
					#1;
				end
				OP_DRAIN: begin
					n = 0;
					while ((exp_q.size() != 0 || irq_seen < bells_exp) && n < WAIT_LIMIT) begin
						@(posedge core_clk);
						#1;
						n++;
					end
					assert (n < WAIT_LIMIT) else begin
						errors++;
						$display("drain stalled with %0d messages still expected", exp_q.size());
					end
					check_value("doorbell irq pulses", 32'(irq_seen), 32'(bells_exp));
				end
				OP_LED: begin
					check_value("o_led", {28'h0, led}, st.exp_rdata);
				end
				default: begin
					apb_write(st.offset, st.data, err);
					check_value("core reset right after request", {31'h0, core_rst_n}, 32'h0);
					n = 0;
					while (!core_rst_n && n < WAIT_LIMIT) begin
						@(posedge core_clk);
						#1;
						n++;
					end
					check_value("core reset low cycles", 32'(n), {16'h0, st.exp_rdata[15:0]});
					m = 0;
					if (st.exp_rdata[31:16] != 16'h0) begin
						while (core_rst_n && m < WAIT_LIMIT) begin
							@(posedge core_clk);
							#1;
							m++;
						end
						check_value("core active cycles", 32'(m), {16'h0, st.exp_rdata[31:16]});
					end else begin
						// zero active count keeps the core running
						repeat (20) begin
							@(posedge core_clk);
							#1;
							m = m + (core_rst_n ? 0 : 1);
						end
						check_value("core reset drops with zero active", 32'(m), 32'h0);
					end
				end
			endcase
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
hw/msgq_pkg.sv
hw/apb_msg_regs.sv
hw/msg_fifo.sv
hw/msg_drain.sv
hw/reset_seq.sv
hw/msgq_sys.sv
testbench/msgq_sys_checker.sv
testbench/tb_msgq_sys.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_msgq_sys -f src.f -o sim_msgq \
	&& ./obj_dir/sim_msgq | tee /dev/stderr | grep "Verification passed" > /dev/null \
	&& echo "simulation run OK" \
	|| { echo "simulation run FAILED"; exit 1; }
